//--- dps_utim64.f
+incdir+.
utim_pkg.sv
utim64.sv
dps_utim64.sv
dps_utim64_assert.sv
tb_dps_utim64.sv

//--- dps_utim64.sv
`default_nettype none

`include "utim_config.svh"

module dps_utim64 (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic timer_clock,
	input wire logic req_valid,
	input wire utim_pkg::utim_bus_req_t req,
	output logic req_busy,
	output logic rsp_valid,
	output logic [`UTIM_DATA_W-1:0] rsp_data,
	output logic irq_valid,
	input wire logic irq_ack
);

	// Response source selected by the read in flight
	localparam logic [1:0] SRC_A = 2'd0;
	localparam logic [1:0] SRC_B = 2'd1;
	localparam logic [1:0] SRC_FLAG = 2'd2;

	// Address decode
	logic accept;
	logic hit_a;
	logic hit_b;
	logic sel_a;
	logic sel_b;
	logic flag_rd;
	logic rd_start;
	utim_pkg::utim_reg_req_t reg_req;

	// Timer side
	logic busy_a;
	logic busy_b;
	utim_pkg::utim_rsp_t rsp_a;
	utim_pkg::utim_rsp_t rsp_b;
	logic [`UTIM_CHANNELS-1:0] irq_a;
	logic [`UTIM_CHANNELS-1:0] irq_b;

	// Read sequencing
	utim_pkg::utim_main_state_e state_q;
	logic [1:0] src_q;

	// Interrupt flags
	utim_pkg::utim_irq_state_e irq_state_q;
	logic [`UTIM_IRQ_FLAGS-1:0] irq_pulse;
	logic [`UTIM_IRQ_FLAGS-1:0] flags_q;
	logic flag_valid_q;
	logic [`UTIM_IRQ_FLAGS-1:0] flag_data_q;

	// Only one request while nothing is in flight
	assign accept = req_valid && !req_busy;

	// Offset from each base, wraps below it
	assign hit_a = (req.addr - `UTIM_A_BASE) <= (`UTIM_A_LAST - `UTIM_A_BASE);
	assign hit_b = (req.addr - `UTIM_B_BASE) <= (`UTIM_B_LAST - `UTIM_B_BASE);
	assign sel_a = accept && hit_a;
	assign sel_b = accept && hit_b;
	// 0x1F is read-only, writes fall through
	assign flag_rd = accept && !req.rw && (req.addr == `UTIM_FLAG_ADDR);
	// 0x0F matches nothing and opens no read
	assign rd_start = !req.rw && (sel_a || sel_b || flag_rd);

	// Low offset bits go unchanged to both timers
	assign reg_req = '{
		rw: req.rw,
		addr: req.addr[`UTIM_REG_ADDR_W-1:0],
		data: req.data
	};

	utim64 i_utim64_a (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.timer_clock(timer_clock),
		.req_valid(sel_a),
		.req(reg_req),
		.busy(busy_a),
		.rsp(rsp_a),
		.irq(irq_a)
	);

	utim64 i_utim64_b (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.timer_clock(timer_clock),
		.req_valid(sel_b),
		.req(reg_req),
		.busy(busy_b),
		.rsp(rsp_b),
		.irq(irq_b)
	);

	// Read-wait FSM, remembers who answers
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= utim_pkg::IDLE;
			src_q <= SRC_A;
		end else begin
			case (state_q)
				utim_pkg::IDLE: begin
					if (rd_start) begin
						state_q <= utim_pkg::RD_WAIT;
						if (sel_a) begin
							src_q <= SRC_A;
						end else if (sel_b) begin
							src_q <= SRC_B;
						end else begin
							src_q <= SRC_FLAG;
						end
					end
				end
				utim_pkg::RD_WAIT: begin
					// Every source answers the cycle after acceptance
					if (rsp_valid) begin
						state_q <= utim_pkg::IDLE;
					end
				end
				default: state_q <= utim_pkg::IDLE;
			endcase
		end
	end

	// Timer B on top, timer A below
	assign irq_pulse = {irq_b, irq_a};

	// Sticky flag collector
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq_state_q <= utim_pkg::IRQ_IDLE;
			flags_q <= '0;
		end else begin
			case (irq_state_q)
				utim_pkg::IRQ_IDLE: begin
					flags_q <= flags_q | irq_pulse;
					if (|irq_pulse) begin
						irq_state_q <= utim_pkg::IRQ_PEND;
					end
				end
				utim_pkg::IRQ_PEND: begin
					flags_q <= flags_q | irq_pulse;
					if (irq_ack) begin
						irq_state_q <= utim_pkg::IRQ_FLAG;
					end
				end
				utim_pkg::IRQ_FLAG: begin
					if (flag_rd) begin
						// Keep only what arrived during the read itself
						flags_q <= irq_pulse;
						irq_state_q <= utim_pkg::IRQ_IDLE;
					end else begin
						flags_q <= flags_q | irq_pulse;
					end
				end
				default: irq_state_q <= utim_pkg::IRQ_IDLE;
			endcase
		end
	end

	// Flag read answers at T+1 like the timers
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			flag_valid_q <= 1'b0;
		end else begin
			flag_valid_q <= flag_rd;
		end
	end

	// Value before any reload in the same cycle
	always_ff @(posedge iCLOCK) begin
		if (flag_rd) begin
			flag_data_q <= flags_q;
		end
	end

	assign irq_valid = (irq_state_q == utim_pkg::IRQ_PEND);

	assign req_busy = (state_q != utim_pkg::IDLE) || busy_a || busy_b;
	assign rsp_valid = rsp_a.valid || rsp_b.valid || flag_valid_q;

	// Response mux
	always_comb begin
		case (src_q)
			SRC_A: rsp_data = rsp_a.data;
			SRC_B: rsp_data = rsp_b.data;
			default: rsp_data = {{(`UTIM_DATA_W-`UTIM_IRQ_FLAGS){1'b0}}, flag_data_q};
		endcase
	end

endmodule

`default_nettype wire

//--- dps_utim64_assert.sv
`default_nettype none

`include "utim_config.svh"

module dps_utim64_assert (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic req_valid,
	input wire utim_pkg::utim_bus_req_t req,
	input wire logic req_busy,
	input wire logic rsp_valid,
	input wire logic irq_valid,
	input wire logic irq_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	logic mapped;
	logic rd_accept;

	// 0x0F sits between the timers and never answers
	assign mapped = (req.addr <= `UTIM_A_LAST) || (req.addr >= `UTIM_B_BASE);
	assign rd_accept = req_valid && !req_busy && !req.rw && mapped;

	// Response only right after an accepted read
	rsp_after_read: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rsp_valid |-> $past(rd_accept))
		else $error("rsp_valid without an accepted read one cycle earlier");

	// Busy covers the response cycle
	busy_after_read: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_accept |=> req_busy)
		else $error("req_busy low in the cycle after an accepted read");

	// Interrupt level drops only on acknowledge
	irq_fall_on_ack: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$fell(irq_valid) |-> $past(irq_ack))
		else $error("irq_valid fell without irq_ack");

	// Master holds off while busy
	no_req_when_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		req_busy |-> !req_valid)
		else $error("req_valid raised while req_busy was high");

endmodule

bind dps_utim64 dps_utim64_assert i_dps_utim64_assert (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.req_valid(req_valid),
	.req(req),
	.req_busy(req_busy),
	.rsp_valid(rsp_valid),
	.irq_valid(irq_valid),
	.irq_ack(irq_ack)
);

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps --top-module tb_dps_utim64 \
	-f dps_utim64.f -o tb_dps_utim64
./obj_dir/tb_dps_utim64

//--- tb_dps_utim64.sv
`default_nettype none

`include "utim_config.svh"

module tb_dps_utim64;
	timeunit 1ns;
	timeprecision 1ps;

	// Table entry kinds
	typedef enum logic [2:0] {
		WRITE, READ, HOLD, WAIT_IRQ, ACK, CNT_PAIR, CNT_SAME
	} op_e;

	// HOLD uses data as cycle count and exp as irq_valid level
	typedef struct packed {
		op_e kind;
		logic [`UTIM_ADDR_W-1:0] addr;
		logic [`UTIM_DATA_W-1:0] data;
		logic [`UTIM_DATA_W-1:0] exp;
	} entry_t;

	logic iCLOCK;
	logic inRESET;
	logic timer_clock;
	logic req_valid;
	utim_pkg::utim_bus_req_t req;
	logic req_busy;
	logic rsp_valid;
	logic [`UTIM_DATA_W-1:0] rsp_data;
	logic irq_valid;
	logic irq_ack;

	entry_t table_q[$];
	int unsigned cycles = 0;
	int unsigned limit = 0;
	// Last counter pair, for the stopped-counter check
	logic [`UTIM_DATA_W-1:0] last_lo;
	logic [`UTIM_DATA_W-1:0] last_hi;

	dps_utim64 i_dps_utim64 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.timer_clock(timer_clock),
		.req_valid(req_valid),
		.req(req),
		.req_busy(req_busy),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.irq_valid(irq_valid),
		.irq_ack(irq_ack)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	// Slow timer clock, six iCLOCK periods
	initial begin
		timer_clock = 1'b0;
		forever begin
			repeat (3) @(negedge iCLOCK);
			timer_clock = ~timer_clock;
		end
	end

	// Watchdog, armed once the table length is known
	initial begin
		while (limit == 0 || cycles < limit) begin
			@(posedge iCLOCK);
			cycles++;
		end
		$display("Timeout: run went past %0d cycles", limit);
		$display("Testbench failed");
		$fatal(1, "Watchdog expired");
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("Testbench failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic logic [4:0] timer_addr(input logic [4:0] base, input logic [3:0] off);
		return base | {1'b0, off};
	endfunction

	task automatic add_entry(input op_e kind, input logic [4:0] addr,
		input logic [31:0] data, input logic [31:0] exp);
		table_q.push_back('{kind: kind, addr: addr, data: data, exp: exp});
	endtask

	task automatic set_counter(input logic [4:0] base, input logic [63:0] value);
		add_entry(WRITE, timer_addr(base, utim_pkg::CNT_LO), value[31:0], '0);
		add_entry(WRITE, timer_addr(base, utim_pkg::CNT_HI), value[63:32], '0);
	endtask

	// Low word at 4 + 2*ch, high word right above
	task automatic set_compare(input logic [4:0] base, input int ch, input logic [63:0] value);
		add_entry(WRITE, timer_addr(base, 4'(4 + 2 * ch)), value[31:0], '0);
		add_entry(WRITE, timer_addr(base, 4'(5 + 2 * ch)), value[63:32], '0);
	endtask

	// Drive on the falling edge, accepted at the next rising edge
	task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
		while (req_busy)
			@(negedge iCLOCK);
		req = '{rw: 1'b1, addr: addr, data: data};
		req_valid = 1'b1;
		@(negedge iCLOCK);
		req_valid = 1'b0;
	endtask

	task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
		while (req_busy)
			@(negedge iCLOCK);
		req = '{rw: 1'b0, addr: addr, data: '0};
		req_valid = 1'b1;
		@(negedge iCLOCK);
		// Response cycle T+1
		check_value("rsp_valid", 32'(rsp_valid), 32'd1);
		check_value("req_busy", 32'(req_busy), 32'd1);
		data = rsp_data;
		req_valid = 1'b0;
	endtask

	task automatic build_table();
		logic [31:0] vals [2][16];
		logic [4:0] base;
		logic [63:0] pre;
		logic [31:0] pre_lo;
		logic [31:0] pre_hi;
		int ch;
		int ch_b;
		int off;
		int off_b;
		// Readback on both timers, counters stopped
		for (int t = 0; t < 2; t++) begin
			base = (t == 0) ? `UTIM_A_BASE : `UTIM_B_BASE;
			for (int r = 1; r <= 11; r++) begin
				vals[t][r] = $urandom;
				add_entry(WRITE, timer_addr(base, 4'(r)), vals[t][r], '0);
			end
			add_entry(READ, timer_addr(base, utim_pkg::CTRL), '0, '0);
			for (int r = 1; r <= 11; r++) begin
				// Mask keeps only the channel bits
				add_entry(READ, timer_addr(base, 4'(r)), '0, (4'(r) == utim_pkg::CMP_EN) ?
					32'(vals[t][r][`UTIM_CHANNELS-1:0]) : vals[t][r]);
			end
			add_entry(WRITE, timer_addr(base, utim_pkg::CMP_EN), '0, '0);
		end
		// Decode isolation between timers
		add_entry(WRITE, timer_addr(`UTIM_B_BASE, utim_pkg::CMP1_LO), ~vals[1][6], '0);
		add_entry(READ, timer_addr(`UTIM_A_BASE, utim_pkg::CMP1_LO), '0, vals[0][6]);
		add_entry(READ, timer_addr(`UTIM_B_BASE, utim_pkg::CMP1_LO), '0, ~vals[1][6]);
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CMP2_HI), ~vals[0][9], '0);
		add_entry(READ, timer_addr(`UTIM_B_BASE, utim_pkg::CMP2_HI), '0, vals[1][9]);
		add_entry(READ, timer_addr(`UTIM_A_BASE, utim_pkg::CMP2_HI), '0, ~vals[0][9]);
		for (int r = 12; r <= 14; r++) begin
			add_entry(READ, timer_addr(`UTIM_A_BASE, 4'(r)), '0, '0);
			add_entry(READ, timer_addr(`UTIM_B_BASE, 4'(r)), '0, '0);
		end
		// Count across a 32-bit carry, then read the pair twice
		pre_lo = 32'hFFFF_FFFF - ($urandom % 4);
		pre_hi = $urandom;
		set_counter(`UTIM_A_BASE, {pre_hi, pre_lo});
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CTRL), 32'd1, '0);
		add_entry(HOLD, '0, 32'd60, '0);
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CTRL), '0, '0);
		add_entry(CNT_PAIR, `UTIM_A_BASE, pre_lo, pre_hi);
		add_entry(HOLD, '0, 32'd12, '0);
		add_entry(CNT_SAME, `UTIM_A_BASE, '0, '0);
		// One enabled channel on timer B
		ch = $urandom % 4;
		off = 1 + $urandom % 6;
		pre = {$urandom, $urandom};
		set_counter(`UTIM_B_BASE, pre);
		set_compare(`UTIM_B_BASE, ch, pre + 64'(off));
		add_entry(WRITE, timer_addr(`UTIM_B_BASE, utim_pkg::CMP_EN), 32'(1) << ch, '0);
		add_entry(WRITE, timer_addr(`UTIM_B_BASE, utim_pkg::CTRL), 32'd1, '0);
		add_entry(WAIT_IRQ, '0, '0, '0);
		add_entry(ACK, '0, '0, '0);
		add_entry(READ, `UTIM_FLAG_ADDR, '0, 32'(1) << (ch + 4));
		add_entry(READ, `UTIM_FLAG_ADDR, '0, '0);
		add_entry(WRITE, timer_addr(`UTIM_B_BASE, utim_pkg::CTRL), '0, '0);
		add_entry(WRITE, timer_addr(`UTIM_B_BASE, utim_pkg::CMP_EN), '0, '0);
		// Masked channel on timer A passes its compare silently
		ch = $urandom % 4;
		off = 1 + $urandom % 6;
		pre = {$urandom, $urandom};
		set_counter(`UTIM_A_BASE, pre);
		for (int c = 0; c < 4; c++) begin
			// Others sit on the start value, never reached by an increment
			set_compare(`UTIM_A_BASE, c, (c == ch) ? pre + 64'(off) : pre);
		end
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CMP_EN),
			32'hF & ~(32'(1) << ch), '0);
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CTRL), 32'd1, '0);
		add_entry(HOLD, '0, 32'((off + 4) * 6), '0);
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CTRL), '0, '0);
		add_entry(READ, `UTIM_FLAG_ADDR, '0, '0);
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CMP_EN), '0, '0);
		// Both timers match before the acknowledge
		ch = $urandom % 4;
		ch_b = $urandom % 4;
		off = 1 + $urandom % 6;
		off_b = 1 + $urandom % 6;
		pre = {$urandom, $urandom};
		set_counter(`UTIM_A_BASE, pre);
		set_counter(`UTIM_B_BASE, pre);
		set_compare(`UTIM_A_BASE, ch, pre + 64'(off));
		set_compare(`UTIM_B_BASE, ch_b, pre + 64'(off_b));
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CMP_EN), 32'(1) << ch, '0);
		add_entry(WRITE, timer_addr(`UTIM_B_BASE, utim_pkg::CMP_EN), 32'(1) << ch_b, '0);
		add_entry(WRITE, timer_addr(`UTIM_A_BASE, utim_pkg::CTRL), 32'd1, '0);
		add_entry(WRITE, timer_addr(`UTIM_B_BASE, utim_pkg::CTRL), 32'd1, '0);
		add_entry(WAIT_IRQ, '0, '0, '0);
		// Level holds while the second match lands
		add_entry(HOLD, '0, 32'd90, 32'd1);
		add_entry(ACK, '0, '0, '0);
		add_entry(READ, `UTIM_FLAG_ADDR, '0, (32'(1) << ch) | (32'(1) << (ch_b + 4)));
		add_entry(READ, `UTIM_FLAG_ADDR, '0, '0);
	endtask

	task automatic apply_entry(input entry_t e);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] data;
		int n;
		case (e.kind)
			WRITE: bus_write(e.addr, e.data);
			READ: begin
				bus_read(e.addr, data);
				check_value($sformatf("rsp_data at %h", e.addr), data, e.exp);
			end
			HOLD: begin
				repeat (e.data) begin
					@(negedge iCLOCK);
					check_value("irq_valid", 32'(irq_valid), e.exp);
				end
			end
			WAIT_IRQ: begin
				n = 0;
				while (!irq_valid && n < 400) begin
					@(negedge iCLOCK);
					n++;
				end
				if (!irq_valid) begin
					$display("irq_valid did not rise within 400 cycles");
					$display("Testbench failed");
					$fatal(1, "Interrupt wait timed out");
				end
			end
			ACK: begin
				irq_ack = 1'b1;
				@(negedge iCLOCK);
				irq_ack = 1'b0;
				check_value("irq_valid", 32'(irq_valid), '0);
			end
			CNT_PAIR: begin
				bus_read(timer_addr(e.addr, utim_pkg::CNT_LO), lo);
				bus_read(timer_addr(e.addr, utim_pkg::CNT_HI), hi);
				// Low word wrapped, so the high word moved by one
				check_value("cnt_lo wrapped", 32'(lo < e.data), 32'd1);
				check_value("cnt_hi", hi, e.exp + 32'(lo < e.data));
				last_lo = lo;
				last_hi = hi;
			end
			CNT_SAME: begin
				bus_read(timer_addr(e.addr, utim_pkg::CNT_LO), lo);
				bus_read(timer_addr(e.addr, utim_pkg::CNT_HI), hi);
				check_value("cnt_lo", lo, last_lo);
				check_value("cnt_hi", hi, last_hi);
			end
			default: ;
		endcase
	endtask

	initial begin
		void'($urandom(32'h1198_f15c));
		inRESET = 1'b0;
		req_valid = 1'b0;
		req = '0;
		irq_ack = 1'b0;
		build_table();
		limit = table_q.size() * 300;
		repeat (8) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);
		foreach (table_q[i]) begin
			apply_entry(table_q[i]);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- utim64.sv
`default_nettype none

`include "utim_config.svh"

module utim64 (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic timer_clock,
	input wire logic req_valid,
	input wire utim_pkg::utim_reg_req_t req,
	output logic busy,
	output utim_pkg::utim_rsp_t rsp,
	output logic [`UTIM_CHANNELS-1:0] irq
);

	typedef logic [`UTIM_REG_ADDR_W-1:0] reg_addr_t;

	// Tick synchronizer
	logic [`UTIM_SYNC_STAGES-1:0] tclk_sync;
	logic tclk_prev;
	logic tick;

	// Control and counter
	logic enable;
	logic [`UTIM_CNT_W-1:0] cnt;
	logic inc;
	logic inc_q;
	logic cnt_lo_wr;
	logic cnt_hi_wr;

	// Compare channels
	logic [`UTIM_CHANNELS-1:0] cmp_en;
	logic [`UTIM_CNT_W-1:0] cmp [`UTIM_CHANNELS];

	// Bus side
	logic wr;
	logic rd;
	logic [`UTIM_CNT_W-`UTIM_DATA_W-1:0] snap_hi;
	logic [`UTIM_DATA_W-1:0] rd_data;
	logic rsp_valid_q;
	logic [`UTIM_DATA_W-1:0] rsp_data_q;

	// Offset of a channel's low compare word
	function automatic reg_addr_t cmp_lo_addr(input int ch);
		return reg_addr_t'(utim_pkg::CMP0_LO) + reg_addr_t'(2 * ch);
	endfunction

	assign wr = req_valid && req.rw;
	assign rd = req_valid && !req.rw;

	// Counter half writes win over a tick
	assign cnt_lo_wr = wr && (req.addr == utim_pkg::CNT_LO);
	assign cnt_hi_wr = wr && (req.addr == utim_pkg::CNT_HI);

	// timer_clock shifts in, MSB is the synchronized level
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tclk_sync <= '0;
			tclk_prev <= 1'b0;
		end else begin
			tclk_sync <= {tclk_sync[`UTIM_SYNC_STAGES-2:0], timer_clock};
			tclk_prev <= tclk_sync[`UTIM_SYNC_STAGES-1];
		end
	end

	// Rising edge of the slow clock, one iCLOCK wide
	assign tick = tclk_sync[`UTIM_SYNC_STAGES-1] && !tclk_prev;
	assign inc = tick && enable && !cnt_lo_wr && !cnt_hi_wr;

	// Counter, enable, mask and compare registers
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			enable <= 1'b0;
			cnt <= '0;
			inc_q <= 1'b0;
			cmp_en <= '0;
			for (int i = 0; i < `UTIM_CHANNELS; i++) begin
				cmp[i] <= '0;
			end
		end else begin
			inc_q <= inc;
			if (cnt_lo_wr) begin
				cnt <= {cnt[`UTIM_CNT_W-1:`UTIM_DATA_W], req.data};
			end else if (cnt_hi_wr) begin
				cnt <= {req.data, cnt[`UTIM_DATA_W-1:0]};
			end else if (inc) begin
				cnt <= cnt + 1'b1;
			end
			if (wr) begin
				case (req.addr)
					utim_pkg::CTRL: enable <= req.data[0];
					utim_pkg::CMP_EN: cmp_en <= req.data[`UTIM_CHANNELS-1:0];
					default: ;
				endcase
				// Compare halves, one lo/hi pair per channel
				for (int i = 0; i < `UTIM_CHANNELS; i++) begin
					if (req.addr == cmp_lo_addr(i)) begin
						cmp[i][`UTIM_DATA_W-1:0] <= req.data;
					end
					if (req.addr == cmp_lo_addr(i) + 1'b1) begin
						cmp[i][`UTIM_CNT_W-1:`UTIM_DATA_W] <= req.data;
					end
				end
			end
		end
	end

	// Match check one cycle after the increment landed
	// inc_q keeps a written counter value from firing
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq <= '0;
		end else begin
			for (int i = 0; i < `UTIM_CHANNELS; i++) begin
				irq[i] <= inc_q && cmp_en[i] && (cnt == cmp[i]);
			end
		end
	end

	// Read mux, unused offsets stay zero
	always_comb begin
		rd_data = '0;
		case (req.addr)
			utim_pkg::CTRL: rd_data[0] = enable;
			utim_pkg::CNT_LO: rd_data = cnt[`UTIM_DATA_W-1:0];
			// Upper half as captured by the last low read
			utim_pkg::CNT_HI: rd_data = snap_hi;
			utim_pkg::CMP_EN: rd_data[`UTIM_CHANNELS-1:0] = cmp_en;
			default: ;
		endcase
		for (int i = 0; i < `UTIM_CHANNELS; i++) begin
			if (req.addr == cmp_lo_addr(i)) begin
				rd_data = cmp[i][`UTIM_DATA_W-1:0];
			end
			if (req.addr == cmp_lo_addr(i) + 1'b1) begin
				rd_data = cmp[i][`UTIM_CNT_W-1:`UTIM_DATA_W];
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= rd;
		end
	end

	// Read data and snapshot
	always_ff @(posedge iCLOCK) begin
		if (rd) begin
			rsp_data_q <= rd_data;
		end
		// Low read freezes the high word for the pair
		if (rd && (req.addr == utim_pkg::CNT_LO)) begin
			snap_hi <= cnt[`UTIM_CNT_W-1:`UTIM_DATA_W];
		end
	end

	assign rsp = '{valid: rsp_valid_q, data: rsp_data_q};
	// Busy only during the response cycle
	assign busy = rsp_valid_q;

endmodule

`default_nettype wire

//--- utim_config.svh
`ifndef UTIM_CONFIG_SVH
`define UTIM_CONFIG_SVH

// Bus data width, one register word
`define UTIM_DATA_W 32
// Counter and compare width
`define UTIM_CNT_W 64

// Top-level address, 32 word slots
`define UTIM_ADDR_W 5
// Address seen by one timer
`define UTIM_REG_ADDR_W 4

// Compare channels per timer
`define UTIM_CHANNELS 4
// Sticky flags, timer B in the upper half
`define UTIM_IRQ_FLAGS 8

// Flops between timer_clock and the edge detector
`define UTIM_SYNC_STAGES 2

// Address map
`define UTIM_A_BASE 5'h00
`define UTIM_A_LAST 5'h0E
`define UTIM_B_BASE 5'h10
`define UTIM_B_LAST 5'h1E
`define UTIM_FLAG_ADDR 5'h1F

`endif

//--- utim_pkg.sv
`default_nettype none

`include "utim_config.svh"

package utim_pkg;

	// Request at the external bus, full address
	typedef struct packed {
		logic rw;
		logic [`UTIM_ADDR_W-1:0] addr;
		logic [`UTIM_DATA_W-1:0] data;
	} utim_bus_req_t;

	// Same request after decode, timer-local offset only
	typedef struct packed {
		logic rw;
		logic [`UTIM_REG_ADDR_W-1:0] addr;
		logic [`UTIM_DATA_W-1:0] data;
	} utim_reg_req_t;

	// Read response of one timer
	typedef struct packed {
		logic valid;
		logic [`UTIM_DATA_W-1:0] data;
	} utim_rsp_t;

	// Timer register offsets, compares as lo/hi pairs
	typedef enum logic [`UTIM_REG_ADDR_W-1:0] {
		CTRL    = 4'h0,
		CNT_LO  = 4'h1,
		CNT_HI  = 4'h2,
		CMP_EN  = 4'h3,
		CMP0_LO = 4'h4,
		CMP0_HI = 4'h5,
		CMP1_LO = 4'h6,
		CMP1_HI = 4'h7,
		CMP2_LO = 4'h8,
		CMP2_HI = 4'h9,
		CMP3_LO = 4'hA,
		CMP3_HI = 4'hB
	} utim_reg_e;

	// Bus read sequencing
	typedef enum logic {
		IDLE,
		RD_WAIT
	} utim_main_state_e;

	// Interrupt / acknowledge / flag-read sequence
	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_PEND,
		IRQ_FLAG
	} utim_irq_state_e;

endpackage

`default_nettype wire
